// File: Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module btac_tb -f all.f

run: compile
	@out="$$(./obj_dir/Vbtac_tb)"; echo "$$out"; echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

// File: all.f
source/btac_pkg.sv
source/btb.sv
source/btac_queue.sv
source/btac_ctrl.sv
source/btac.sv
verification/btac_model.sv
verification/btac_tb.sv

// File: source/btac.sv
`timescale 1ns/1ps

module btac
  import btac_pkg::*;
#(
  parameter int btb_entries = 64,
  parameter int queue_depth = 8
) (
  input logic clock,
  input logic reset,
  input btac_in_t btac_in,
  output btac_out_t btac_out
);

  logic [$clog2(btb_entries)-1:0] raddr0;
  logic [$clog2(btb_entries)-1:0] raddr1;
  logic [$clog2(btb_entries)-1:0] waddr;
  logic wen;
  btb_entry_t wdata;
  btb_entry_t rdata0;
  btb_entry_t rdata1;

  logic push;
  logic pop;
  logic clear;
  logic pop_valid;
  pred_record_t push_data;
  pred_record_t pop_data;

  btb #(
    .btb_entries(btb_entries)
  ) btb_inst (
    .clock(clock),
    .raddr0(raddr0),
    .raddr1(raddr1),
    .waddr(waddr),
    .wen(wen),
    .wdata(wdata),
    .rdata0(rdata0),
    .rdata1(rdata1)
  );

  btac_queue #(
    .queue_depth(queue_depth)
  ) queue_inst (
    .clock(clock),
    .reset(reset),
    .push(push),
    .push_data(push_data),
    .pop(pop),
    .clear(clear),
    .pop_data(pop_data),
    .pop_valid(pop_valid)
  );

  btac_ctrl #(
    .btb_entries(btb_entries)
  ) ctrl_inst (
    .clock(clock),
    .reset(reset),
    .btac_in(btac_in),
    .btac_out(btac_out),
    .raddr0(raddr0),
    .raddr1(raddr1),
    .wen(wen),
    .waddr(waddr),
    .wdata(wdata),
    .rdata0(rdata0),
    .rdata1(rdata1),
    .push(push),
    .push_data(push_data),
    .pop(pop),
    .clear(clear),
    .pop_data(pop_data),
    .pop_valid(pop_valid)
  );

endmodule

// File: source/btac_ctrl.sv
`timescale 1ns/1ps

module btac_ctrl
  import btac_pkg::*;
#(
  parameter int btb_entries = 64
) (
  input logic clock,
  input logic reset,
  input btac_in_t btac_in,
  output btac_out_t btac_out,
  output logic [$clog2(btb_entries)-1:0] raddr0,
  output logic [$clog2(btb_entries)-1:0] raddr1,
  output logic wen,
  output logic [$clog2(btb_entries)-1:0] waddr,
  output btb_entry_t wdata,
  input btb_entry_t rdata0,
  input btb_entry_t rdata1,
  output logic push,
  output pred_record_t push_data,
  output logic pop,
  output logic clear,
  input pred_record_t pop_data,
  input logic pop_valid
);

  localparam int index_width = $clog2(btb_entries);

  typedef logic [index_width-1:0] index_t;

  typedef struct packed {
    addr_t pc0;                       // fetch PCs of the lookup in flight
    addr_t pc1;
    logic cti;
    logic miss0;
    logic miss1;
    addr_t maddr;
  } state_t;

  state_t r;
  state_t rin;

  logic hit0;
  logic hit1;
  logic predict;
  logic taken0;
  logic taken1;
  logic head_valid;
  logic match0;
  logic match1;
  btb_entry_t hit_entry;

  function automatic index_t pc_index(addr_t pc);
    return pc[index_width+1:2];
  endfunction

  always_comb begin
    rin = r;
    rin.pc0 = btac_in.get_pc0;
    rin.pc1 = btac_in.get_pc1;
    rin.cti = btac_in.get_cti0 | btac_in.get_cti1;

    raddr0 = pc_index(btac_in.get_pc0);
    raddr1 = pc_index(btac_in.get_pc1);

    // a hit needs a live entry tagged with the full PC, slot 0 first
    hit0 = (rdata0 != '0) && (rdata0.pc == r.pc0);
    hit1 = (rdata1 != '0) && (rdata1.pc == r.pc1);
    hit_entry = hit0 ? rdata0 : rdata1;
    predict = ~(btac_in.stall | btac_in.flush);

    btac_out.pred_branch = predict & (hit0 | hit1);
    if (btac_out.pred_branch) begin
      btac_out.pred_target = hit_entry.target;
      btac_out.pred_pc = hit_entry.pc;
      btac_out.pred_npc = hit_entry.npc;
    end else begin
      btac_out.pred_target = '0;
      btac_out.pred_pc = '0;
      btac_out.pred_npc = '0;
    end

    push = predict & r.cti;
    push_data.taken = btac_out.pred_branch;
    push_data.entry.target = btac_out.pred_target;
    push_data.entry.pc = btac_out.pred_pc;
    push_data.entry.npc = btac_out.pred_npc;

    // only taken jumps are installed
    taken0 = btac_in.upd_cti0 & btac_in.upd_taken0;
    taken1 = btac_in.upd_cti1 & btac_in.upd_taken1;
    wen = taken0 | taken1;
    if (taken0) begin
      waddr = pc_index(btac_in.upd_pc0);
      wdata = '{target: btac_in.upd_addr0, pc: btac_in.upd_pc0, npc: btac_in.upd_npc0};
    end else begin
      waddr = pc_index(btac_in.upd_pc1);
      wdata = '{target: btac_in.upd_addr1, pc: btac_in.upd_pc1, npc: btac_in.upd_npc1};
    end

    // the queue is emptied the cycle after a miss so its head is stale
    clear = r.miss0 | r.miss1;
    head_valid = pop_valid & ~clear;
    pop = (btac_in.upd_cti0 | btac_in.upd_cti1) & head_valid;
    match0 = head_valid & pop_data.taken & btac_in.upd_cti0 &
             (btac_in.upd_pc0 == pop_data.entry.pc);
    match1 = head_valid & pop_data.taken & btac_in.upd_cti1 &
             (btac_in.upd_pc1 == pop_data.entry.pc);

    rin.miss0 = 1'b0;
    rin.miss1 = 1'b0;
    rin.maddr = '0;
    if (match0) begin
      if (btac_in.upd_taken0) begin
        rin.miss0 = btac_in.upd_addr0 != pop_data.entry.target;
        rin.maddr = btac_in.upd_addr0;
      end else begin
        rin.miss0 = 1'b1;               // predicted taken but fell through
        rin.maddr = pop_data.entry.npc;
      end
    end else if (match1) begin
      if (btac_in.upd_taken1) begin
        rin.miss1 = btac_in.upd_addr1 != pop_data.entry.target;
        rin.maddr = btac_in.upd_addr1;
      end else begin
        rin.miss1 = 1'b1;
        rin.maddr = pop_data.entry.npc;
      end
    end else if (taken0) begin
      rin.miss0 = 1'b1;                 // taken without a matching prediction
      rin.maddr = btac_in.upd_addr0;
    end else if (taken1) begin
      rin.miss1 = 1'b1;
      rin.maddr = btac_in.upd_addr1;
    end

    btac_out.pred_miss = r.miss0 | r.miss1;
    btac_out.pred_maddr = r.maddr;
    btac_out.pred_hazard = rin.miss0;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      r <= '0;
    end else begin
      r <= rin;
    end
  end

  // a redirect to zero is only legal when a zero address was actually resolved
  assert property (@(posedge clock) disable iff (!reset)
    btac_out.pred_miss |-> btac_out.pred_maddr != '0 ||
      $past((btac_in.upd_cti0 && btac_in.upd_addr0 == '0) ||
            (btac_in.upd_cti1 && btac_in.upd_addr1 == '0) ||
            (head_valid && pop_data.entry.npc == '0)));

endmodule

// File: source/btac_pkg.sv
package btac_pkg;

  typedef logic [31:0] addr_t;

  // an all-zero entry marks an empty slot
  typedef struct packed {
    addr_t target;
    addr_t pc;
    addr_t npc;
  } btb_entry_t;

  // one prediction waiting for its instruction to resolve
  typedef struct packed {
    logic taken;
    btb_entry_t entry;
  } pred_record_t;

  typedef struct packed {
    addr_t get_pc0;
    addr_t get_pc1;
    logic get_cti0;                   // fetched slot holds a jump or branch
    logic get_cti1;
    addr_t upd_pc0;
    addr_t upd_npc0;
    addr_t upd_addr0;                 // resolved target of slot 0
    addr_t upd_pc1;
    addr_t upd_npc1;
    addr_t upd_addr1;
    logic upd_cti0;                   // slot resolves a jump or branch
    logic upd_cti1;
    logic upd_taken0;
    logic upd_taken1;
    logic stall;
    logic flush;
  } btac_in_t;

  typedef struct packed {
    logic pred_branch;
    addr_t pred_target;
    addr_t pred_pc;
    addr_t pred_npc;
    logic pred_miss;
    addr_t pred_maddr;                // redirect address on a miss
    logic pred_hazard;
  } btac_out_t;

endpackage

// File: source/btac_queue.sv
`timescale 1ns/1ps

module btac_queue
  import btac_pkg::*;
#(
  parameter int queue_depth = 8
) (
  input logic clock,
  input logic reset,
  input logic push,
  input pred_record_t push_data,
  input logic pop,
  input logic clear,
  output pred_record_t pop_data,
  output logic pop_valid
);

  localparam int ptr_width = $clog2(queue_depth);
  localparam logic [ptr_width:0] depth_count = queue_depth[ptr_width:0];

  pred_record_t mem [queue_depth];

  logic [ptr_width-1:0] rptr;
  logic [ptr_width-1:0] wptr;
  logic [ptr_width:0] count;
  logic full;
  logic do_push;
  logic do_pop;

  assign full = count == depth_count;
  assign pop_valid = count != '0;
  assign do_push = push & ~full & ~clear;   // a push into a full queue is lost
  assign do_pop = pop & pop_valid & ~clear;
  assign pop_data = mem[rptr];

  always_ff @(posedge clock) begin
    if (!reset || clear) begin
      rptr <= '0;
      wptr <= '0;
      count <= '0;
    end else begin
      if (do_push) begin
        wptr <= wptr + 1'b1;            // wraps since the depth is a power of two
      end
      if (do_pop) begin
        rptr <= rptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wptr] <= push_data;
    end
  end

  assert property (@(posedge clock) disable iff (!reset) count <= depth_count);

  // the control block only pops a head it has seen as valid
  assert property (@(posedge clock) disable iff (!reset) pop |-> pop_valid);

  assert property (@(posedge clock) disable iff (!reset) push && !clear |-> !full)
    else $warning("btac_queue: prediction dropped, queue full");

endmodule

// File: source/btb.sv
`timescale 1ns/1ps

module btb
  import btac_pkg::*;
#(
  parameter int btb_entries = 64
) (
  input logic clock,
  input logic [$clog2(btb_entries)-1:0] raddr0,
  input logic [$clog2(btb_entries)-1:0] raddr1,
  input logic [$clog2(btb_entries)-1:0] waddr,
  input logic wen,
  input btb_entry_t wdata,
  output btb_entry_t rdata0,
  output btb_entry_t rdata1
);

  localparam int index_width = $clog2(btb_entries);

  btb_entry_t mem [btb_entries] = '{default: '0};  // all slots start out empty

  logic [index_width-1:0] raddr0_q = '0;
  logic [index_width-1:0] raddr1_q = '0;

  always_ff @(posedge clock) begin
    raddr0_q <= raddr0;
    raddr1_q <= raddr1;
    if (wen) begin
      mem[waddr] <= wdata;
    end
  end

  // reads see a write made at the edge that captured the index
  assign rdata0 = mem[raddr0_q];
  assign rdata1 = mem[raddr1_q];

endmodule

// File: verification/btac_model.sv
`timescale 1ns/1ps

module btac_model
  import btac_pkg::*;
#(
  parameter int btb_entries = 64,
  parameter int queue_depth = 8
) (
  input logic clock,
  input logic reset,
  input btac_in_t btac_in,
  output btac_out_t expected
);

  typedef logic [$clog2(btb_entries)-1:0] slot_t;

  btb_entry_t table_q [btb_entries] = '{default: '0};
  pred_record_t pending [$];           // oldest prediction at the front
  pred_record_t head;
  logic head_valid = 1'b0;
  addr_t fetch_pc0;
  addr_t fetch_pc1;
  logic fetch_cti;
  logic miss_q;
  addr_t maddr_q;
  btb_entry_t entry0;
  btb_entry_t entry1;
  logic use_head;
  logic miss0;
  logic miss1;
  addr_t next_maddr;

  function automatic slot_t slot_of(addr_t pc);
    return slot_t'((pc >> 2) % btb_entries);
  endfunction

  always_comb begin
    entry0 = table_q[slot_of(fetch_pc0)];
    entry1 = table_q[slot_of(fetch_pc1)];
    expected = '0;
    if (!btac_in.stall && !btac_in.flush) begin
      if (entry0 != '0 && entry0.pc == fetch_pc0) begin
        expected.pred_branch = 1'b1;
        {expected.pred_target, expected.pred_pc, expected.pred_npc} = entry0;
      end else if (entry1 != '0 && entry1.pc == fetch_pc1) begin
        expected.pred_branch = 1'b1;
        {expected.pred_target, expected.pred_pc, expected.pred_npc} = entry1;
      end
    end

    use_head = head_valid && !miss_q;  // a pending miss empties the queue at this edge
    miss0 = 1'b0;
    miss1 = 1'b0;
    next_maddr = '0;
    if (use_head && head.taken && btac_in.upd_cti0 && btac_in.upd_pc0 == head.entry.pc) begin
      miss0 = !btac_in.upd_taken0 || btac_in.upd_addr0 != head.entry.target;
      next_maddr = btac_in.upd_taken0 ? btac_in.upd_addr0 : head.entry.npc;
    end else if (use_head && head.taken && btac_in.upd_cti1 &&
                 btac_in.upd_pc1 == head.entry.pc) begin
      miss1 = !btac_in.upd_taken1 || btac_in.upd_addr1 != head.entry.target;
      next_maddr = btac_in.upd_taken1 ? btac_in.upd_addr1 : head.entry.npc;
    end else if (btac_in.upd_cti0 && btac_in.upd_taken0) begin
      miss0 = 1'b1;
      next_maddr = btac_in.upd_addr0;
    end else if (btac_in.upd_cti1 && btac_in.upd_taken1) begin
      miss1 = 1'b1;
      next_maddr = btac_in.upd_addr1;
    end
    expected.pred_miss = miss_q;
    expected.pred_maddr = maddr_q;
    expected.pred_hazard = miss0;
  end

  always @(posedge clock) begin
    if (!reset) begin
      pending.delete();
      fetch_pc0 <= '0;
      fetch_pc1 <= '0;
      fetch_cti <= 1'b0;
      miss_q <= 1'b0;
      maddr_q <= '0;
    end else begin
      if (miss_q) begin
        pending.delete();
      end else begin
        // the full test sees the queue as it was before this edge
        if (fetch_cti && !btac_in.stall && !btac_in.flush && pending.size() < queue_depth) begin
          pending.push_back(pred_record_t'({expected.pred_branch, expected.pred_target,
                                            expected.pred_pc, expected.pred_npc}));
        end
        if (use_head && (btac_in.upd_cti0 || btac_in.upd_cti1)) begin
          void'(pending.pop_front());
        end
      end
      if (btac_in.upd_cti0 && btac_in.upd_taken0) begin
        table_q[slot_of(btac_in.upd_pc0)] <= {btac_in.upd_addr0, btac_in.upd_pc0,
                                              btac_in.upd_npc0};
      end else if (btac_in.upd_cti1 && btac_in.upd_taken1) begin
        table_q[slot_of(btac_in.upd_pc1)] <= {btac_in.upd_addr1, btac_in.upd_pc1,
                                              btac_in.upd_npc1};
      end
      fetch_pc0 <= btac_in.get_pc0;
      fetch_pc1 <= btac_in.get_pc1;
      fetch_cti <= btac_in.get_cti0 | btac_in.get_cti1;
      miss_q <= miss0 | miss1;
      maddr_q <= next_maddr;
    end
    head_valid <= pending.size() != 0;
    head <= pending.size() != 0 ? pending[0] : '0;
  end

endmodule

// File: verification/btac_tb.sv
`timescale 1ns/1ps

module btac_tb
  import btac_pkg::*;
();

  localparam addr_t pc_a = 32'h0000_1010;
  localparam addr_t pc_alias = 32'h0000_1110;   // same BTB index as pc_a, other tag
  localparam addr_t pc_new = 32'h0000_1020;
  localparam addr_t pc_c = 32'h0000_1034;
  localparam addr_t target_a = 32'h0000_2000;
  localparam addr_t target_b = 32'h0000_3000;
  localparam addr_t target_c = 32'h0000_2400;

  logic clock = 1'b0;
  logic reset;
  btac_in_t stim;
  btac_in_t v_in;
  btac_out_t dut_out;
  btac_out_t model_out;
  btac_out_t want;
  integer seed = 32'h27bc;
  int error_count = 0;
  int check_count = 0;
  int timeout_count = 0;
  int waited;
  string test_name;

  always #5 clock = ~clock;

  btac UUT (.clock(clock), .reset(reset), .btac_in(stim), .btac_out(dut_out));

  btac_model model (.clock(clock), .reset(reset), .btac_in(stim), .expected(model_out));

  task automatic check_pred(input string name, input btac_out_t exp, input btac_out_t act);
    check_count++;
    if ({exp.pred_branch, exp.pred_target, exp.pred_pc, exp.pred_npc} !==
        {act.pred_branch, act.pred_target, act.pred_pc, act.pred_npc}) begin
      error_count++;
      $display("CHECK FAILED %s: prediction expected %b %h %h %h, actual %b %h %h %h", name,
               exp.pred_branch, exp.pred_target, exp.pred_pc, exp.pred_npc,
               act.pred_branch, act.pred_target, act.pred_pc, act.pred_npc);
    end
  endtask

  task automatic check_miss(input string name, input logic exp_miss, input addr_t exp_maddr,
                            input logic act_miss, input addr_t act_maddr);
    check_count++;
    if (act_miss !== exp_miss || (exp_miss && act_maddr !== exp_maddr)) begin
      error_count++;
      $display("CHECK FAILED %s: miss expected %b %h, actual %b %h", name,
               exp_miss, exp_maddr, act_miss, act_maddr);
    end
  endtask

  task automatic check_hazard(input string name, input logic exp, input logic act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("CHECK FAILED %s: hazard expected %b, actual %b", name, exp, act);
    end
  endtask

  // inputs change on the falling edge and outputs settle before the next rising one
  task automatic step(input btac_in_t value);
    @(negedge clock);
    stim = value;
    #4;
    check_pred(test_name, model_out, dut_out);
    check_miss(test_name, model_out.pred_miss, model_out.pred_maddr,
               dut_out.pred_miss, dut_out.pred_maddr);
    check_hazard(test_name, model_out.pred_hazard, dut_out.pred_hazard);
  endtask

  task automatic idle();
    step('0);
  endtask

  task automatic lookup(input addr_t pc, input logic cti);
    btac_in_t v;
    v = '0;
    v.get_pc0 = pc;
    v.get_pc1 = pc + 32'd4;
    v.get_cti0 = cti;
    step(v);
  endtask

  task automatic resolve(input logic slot, input addr_t pc, input logic taken, input addr_t dest);
    btac_in_t v;
    v = '0;
    if (!slot) begin
      {v.upd_cti0, v.upd_taken0, v.upd_pc0, v.upd_npc0} = {1'b1, taken, pc, pc + 32'd4};
      v.upd_addr0 = dest;
    end else begin
      {v.upd_cti1, v.upd_taken1, v.upd_pc1, v.upd_npc1} = {1'b1, taken, pc, pc + 32'd4};
      v.upd_addr1 = dest;
    end
    step(v);
  endtask

  task automatic wait_for_miss();
    int count;
    count = 0;
    do begin
      idle();
      count++;
    end while (!dut_out.pred_miss && count < 4);
    if (!dut_out.pred_miss) begin
      timeout_count++;
      $display("%s: no miss seen within 4 cycles", test_name);
    end
  endtask

  // 16 addresses over 8 BTB indexes, so every index has an alias
  function automatic addr_t pool_pc(input logic [3:0] k);
    return {23'h000008, k[3], 3'b000, k[2:0], 2'b00};
  endfunction

  task automatic random_input(output btac_in_t v);
    logic [31:0] r0;
    logic [31:0] r1;
    r0 = $random(seed);
    r1 = $random(seed);
    v = '0;
    v.get_pc0 = pool_pc(r0[3:0]);
    v.get_pc1 = pool_pc(r0[7:4]);
    v.get_cti0 = r0[9:8] == 2'b00;
    v.get_cti1 = r0[11:10] == 2'b00;
    v.stall = r0[15:12] == 4'h0;
    v.flush = r0[19:16] == 4'h0;
    v.upd_pc0 = pool_pc(r1[3:0]);
    v.upd_npc0 = v.upd_pc0 + 32'd4;
    v.upd_addr0 = {24'h000040, 2'b00, r1[7:4], 2'b00};
    v.upd_pc1 = pool_pc(r1[11:8]);
    v.upd_npc1 = v.upd_pc1 + 32'd4;
    v.upd_addr1 = {24'h000040, 2'b00, r1[15:12], 2'b00};
    v.upd_cti0 = r1[17:16] == 2'b00;
    v.upd_cti1 = r1[19:18] == 2'b00;
    v.upd_taken0 = r1[20];
    v.upd_taken1 = r1[21];
  endtask

  initial begin
    reset = 1'b0;
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
  end

  initial begin
    stim = '0;
    test_name = "reset";
    waited = 0;
    while (reset !== 1'b1 && waited < 10) begin
      @(posedge clock);
      waited++;
    end
    if (reset !== 1'b1) begin
      timeout_count++;
      $display("reset was never released");
    end

    test_name = "idle after reset";
    repeat (3) begin
      idle();
      check_pred(test_name, '0, dut_out);
      check_miss(test_name, 1'b0, '0, dut_out.pred_miss, dut_out.pred_maddr);
      check_hazard(test_name, 1'b0, dut_out.pred_hazard);
    end

    test_name = "install";
    resolve(1'b0, pc_a, 1'b1, target_a);
    lookup(pc_a, 1'b0);
    idle();
    want = '0;
    want.pred_branch = 1'b1;
    want.pred_target = target_a;
    want.pred_pc = pc_a;
    want.pred_npc = pc_a + 32'd4;
    check_pred(test_name, want, dut_out);

    test_name = "no hit";
    lookup(pc_new, 1'b0);
    idle();
    check_pred(test_name, '0, dut_out);
    lookup(pc_alias, 1'b0);
    idle();
    check_pred(test_name, '0, dut_out);

    test_name = "mispredict target";
    lookup(pc_a, 1'b1);
    idle();
    check_pred(test_name, want, dut_out);
    resolve(1'b0, pc_a, 1'b1, target_b);
    check_hazard(test_name, 1'b1, dut_out.pred_hazard);
    wait_for_miss();
    check_miss(test_name, 1'b1, target_b, dut_out.pred_miss, dut_out.pred_maddr);

    test_name = "mispredict fall through";
    lookup(pc_a, 1'b1);
    idle();
    resolve(1'b0, pc_a, 1'b0, target_b);
    check_hazard(test_name, 1'b1, dut_out.pred_hazard);
    wait_for_miss();
    check_miss(test_name, 1'b1, pc_a + 32'd4, dut_out.pred_miss, dut_out.pred_maddr);

    test_name = "stall";
    lookup(pc_a, 1'b1);
    v_in = '0;
    v_in.stall = 1'b1;
    step(v_in);
    check_pred(test_name, '0, dut_out);
    test_name = "flush";
    lookup(pc_a, 1'b1);
    v_in = '0;
    v_in.flush = 1'b1;
    step(v_in);
    check_pred(test_name, '0, dut_out);

    // two queued predictions of pc_a, then a miss on slot 1 empties the queue
    test_name = "cleared queue";
    lookup(pc_a, 1'b1);
    lookup(pc_a, 1'b1);
    idle();
    resolve(1'b1, pc_c, 1'b1, target_c);
    check_hazard(test_name, 1'b0, dut_out.pred_hazard);
    wait_for_miss();
    check_miss(test_name, 1'b1, target_c, dut_out.pred_miss, dut_out.pred_maddr);
    resolve(1'b0, pc_a, 1'b1, target_b);
    check_hazard(test_name, 1'b1, dut_out.pred_hazard);
    wait_for_miss();
    check_miss(test_name, 1'b1, target_b, dut_out.pred_miss, dut_out.pred_maddr);

    test_name = "random";
    repeat (2000) begin
      random_input(v_in);
      step(v_in);
    end
    idle();

    $display("checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
